// File: hdl/mbu_pkg.sv
`default_nettype none

package mbu_pkg;

   //////////////////////////////
   // Sizes
   //////////////////////////////

   // Eight bank registers MB0 to MB7
   localparam int NUM_BANKS = 8;
   localparam int BANK_W    = 8;
   localparam int IDX_W     = 3;
   // Micro-address width of the control unit
   localparam int ADDR_W    = 5;

   //////////////////////////////
   // Address codes
   //////////////////////////////

   // MBP on the read and write micro-address buses
   localparam logic [ADDR_W-1:0] RADDR_MBP       = 5'b01100;
   localparam logic [ADDR_W-1:0] WADDR_MBP       = 5'b01100;
   // Upper waddr bits of the four AR <- MBx loads
   localparam logic [2:0]        WADDR_AR_MBX_HI = 3'b001;
   // I/O window 0x08 to 0x0F
   localparam logic [4:0]        IO_BASE_HI      = 5'b00001;

   //////////////////////////////
   // Types
   //////////////////////////////

   // One decoded access per request
   typedef enum logic [2:0] {
      FUNC_NONE  = 3'd0,
      FUNC_IO_RD = 3'd1,
      FUNC_IO_WR = 3'd2,
      FUNC_CU_RD = 3'd3,
      FUNC_CU_WR = 3'd4,
      FUNC_AR_LD = 3'd5
   } mbu_func_e;

   // Where a read value is headed
   typedef enum logic [1:0] {
      ROUTE_IBUS = 2'd0,
      ROUTE_DB   = 2'd1,
      ROUTE_AR   = 2'd2
   } mbu_route_e;

   // Request as seen on the processor side
   typedef struct packed {
      logic [ADDR_W-1:0] raddr;
      logic [ADDR_W-1:0] waddr;
      logic              idxen;
      logic [IDX_W-1:0]  ir;
      logic [7:0]        ab;
      logic              io_rd;
      logic              io_wr;
      logic [BANK_W-1:0] data;
   } mbu_req_t;

   // Decoder output
   typedef struct packed {
      mbu_func_e         func;
      logic [IDX_W-1:0]  sel;
      logic [BANK_W-1:0] wdata;
   } mbu_ctl_t;

   // Response payload
   typedef struct packed {
      logic [BANK_W-1:0] data;
      mbu_route_e        route;
   } mbu_rsp_t;

   // Power-on value of every bank read
   // Bit 7 follows the front-panel RAM/ROM switch
   function automatic logic [BANK_W-1:0] default_byte(input logic rom_sel);
      default_byte = {rom_sel, {(BANK_W-1){1'b0}}};
   endfunction

endpackage

`default_nettype wire

// File: hdl/mbu_addr_decode.sv
`timescale 1ns/10ps
`default_nettype none

// Request decoder
// Stands in for the address decoders and the control ROM
module mbu_addr_decode (
   input  mbu_pkg::mbu_req_t req,
   output mbu_pkg::mbu_ctl_t ctl
);

   //////////////////////////////
   // Address matches
   //////////////////////////////

   logic                      io_req;
   logic                      io_hit;
   logic                      cu_rd_hit;
   logic                      cu_wr_hit;
   logic                      ar_hit;
   logic [mbu_pkg::IDX_W-1:0] io_sel;
   logic [mbu_pkg::IDX_W-1:0] ar_sel;

   // Any I/O strobe present
   assign io_req    = req.io_rd | req.io_wr;

   // One register per address in 0x08 to 0x0F
   assign io_hit    = io_req && (req.ab[7:3] == mbu_pkg::IO_BASE_HI);

   // MBP read and write micro-addresses
   assign cu_rd_hit = (req.raddr == mbu_pkg::RADDR_MBP);
   assign cu_wr_hit = (req.waddr == mbu_pkg::WADDR_MBP);

   // Group of four waddrs loading AR with an MBx value
   assign ar_hit    = (req.waddr[mbu_pkg::ADDR_W-1:2] == mbu_pkg::WADDR_AR_MBX_HI);

   //////////////////////////////
   // Register index sources
   //////////////////////////////

   // Low address bits pick the register in the I/O window
   assign io_sel = req.ab[mbu_pkg::IDX_W-1:0];

   // Indexed form takes ir
   // plain form takes the two low waddr bits
   assign ar_sel = req.idxen ? req.ir
                             : {{(mbu_pkg::IDX_W-2){1'b0}}, req.waddr[1:0]};

   //////////////////////////////
   // Priority resolution
   //////////////////////////////

   always_comb begin
      // Nothing recognised unless a match below
      ctl.func  = mbu_pkg::FUNC_NONE;
      ctl.sel   = '0;
      // Write data always follows the request
      ctl.wdata = req.data;

      if (io_hit) begin
         // Read strobe wins if both are set
         if (req.io_rd) begin
            ctl.func = mbu_pkg::FUNC_IO_RD;
         end else begin
            ctl.func = mbu_pkg::FUNC_IO_WR;
         end
         ctl.sel = io_sel;
      end else if (cu_rd_hit) begin
         // MBP lives in MB0
         ctl.func = mbu_pkg::FUNC_CU_RD;
         ctl.sel  = '0;
      end else if (cu_wr_hit) begin
         ctl.func = mbu_pkg::FUNC_CU_WR;
         ctl.sel  = '0;
      end else if (ar_hit) begin
         ctl.func = mbu_pkg::FUNC_AR_LD;
         ctl.sel  = ar_sel;
      end
   end

endmodule

`default_nettype wire

// File: hdl/mbu_control.sv
`timescale 1ns/10ps
`default_nettype none

// Handshake, enable flag and response register
module mbu_control (
   input  logic                        clk,
   input  logic                        rst_n,
   input  mbu_pkg::mbu_ctl_t           ctl,
   input  logic                        req_valid,
   input  logic                        rsp_ready,
   input  logic                        rom_sel,
   input  logic [mbu_pkg::BANK_W-1:0]  rd_data,
   output logic                        req_ready,
   output logic                        wr_en,
   output logic                        ar_ld,
   output logic [mbu_pkg::IDX_W-1:0]   rd_sel,
   output logic [mbu_pkg::BANK_W-1:0]  ar_data,
   output mbu_pkg::mbu_rsp_t           rsp,
   output logic                        rsp_valid,
   output logic                        enabled
);

   logic                       accept;
   logic                       enabled_q;
   logic                       rsp_valid_q;
   logic                       has_rsp;
   logic                       is_write;
   logic [mbu_pkg::BANK_W-1:0] rd_val;
   mbu_pkg::mbu_route_e        route_d;
   mbu_pkg::mbu_rsp_t          rsp_q;

   //////////////////////////////
   // Request handshake
   //////////////////////////////

   // Free slot, or the pending response leaves this cycle
   assign req_ready = !rsp_valid_q || rsp_ready;
   assign accept    = req_valid && req_ready;

   // Function classes
   always_comb begin
      has_rsp  = 1'b0;
      is_write = 1'b0;
      route_d  = mbu_pkg::ROUTE_IBUS;
      unique case (ctl.func)
         mbu_pkg::FUNC_IO_RD: begin
            // IN instruction drives DB
            has_rsp = 1'b1;
            route_d = mbu_pkg::ROUTE_DB;
         end
         mbu_pkg::FUNC_CU_RD: begin
            has_rsp = 1'b1;
            route_d = mbu_pkg::ROUTE_IBUS;
         end
         mbu_pkg::FUNC_AR_LD: begin
            // Value heads for AR[23:16]
            has_rsp = 1'b1;
            route_d = mbu_pkg::ROUTE_AR;
         end
         mbu_pkg::FUNC_IO_WR,
         mbu_pkg::FUNC_CU_WR: begin
            is_write = 1'b1;
         end
         default: begin
            // FUNC_NONE is swallowed
            has_rsp  = 1'b0;
         end
      endcase
   end

   // Strobes only fire on an accepted request
   assign wr_en  = accept && is_write;
   assign ar_ld  = accept && (ctl.func == mbu_pkg::FUNC_AR_LD);
   assign rd_sel = ctl.sel;

   //////////////////////////////
   // Enable flag
   //////////////////////////////

   // Cleared by reset, set by the first I/O write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         enabled_q <= 1'b0;
      end else if (accept && (ctl.func == mbu_pkg::FUNC_IO_WR)) begin
         enabled_q <= 1'b1;
      end
   end

   assign enabled = enabled_q;

   // Disabled bank reads as the power-on default
   assign rd_val  = enabled_q ? rd_data : mbu_pkg::default_byte(rom_sel);

   // Same value goes to aext on an AR load
   assign ar_data = rd_val;

   //////////////////////////////
   // Response register
   //////////////////////////////

   // Valid rises one cycle after acceptance
   // and holds until the consumer takes it
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_valid_q <= 1'b0;
      end else if (accept && has_rsp) begin
         rsp_valid_q <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid_q <= 1'b0;
      end
   end

   // Payload only moves on a new read or load
   always_ff @(posedge clk) begin
      if (accept && has_rsp) begin
         rsp_q.data  <= rd_val;
         rsp_q.route <= route_d;
      end
   end

   assign rsp       = rsp_q;
   assign rsp_valid = rsp_valid_q;

endmodule

`default_nettype wire

// File: hdl/mbu_bank_regs.sv
`timescale 1ns/10ps
`default_nettype none

// Bank register file MB0 to MB7 and the address extension
module mbu_bank_regs (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        wr_en,
   input  logic                        ar_ld,
   input  logic [mbu_pkg::IDX_W-1:0]   sel,
   input  logic [mbu_pkg::BANK_W-1:0]  wdata,
   input  logic [mbu_pkg::BANK_W-1:0]  ar_data,
   input  logic                        rom_sel,
   output logic [mbu_pkg::BANK_W-1:0]  rd_data,
   output logic [mbu_pkg::BANK_W-1:0]  aext
);

   //////////////////////////////
   // Register file
   //////////////////////////////

   // Behaves like the SRAM it replaces
   // Contents are random until written
   logic [mbu_pkg::BANK_W-1:0] mb [mbu_pkg::NUM_BANKS];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mb[sel] <= wdata;
      end
   end

   // Asynchronous read port
   assign rd_data = mb[sel];

   //////////////////////////////
   // Address extension
   //////////////////////////////

   logic [mbu_pkg::BANK_W-1:0] aext_q;
   logic                       aext_loaded;

   // Tracks whether AR has ever been loaded since reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         aext_loaded <= 1'b0;
      end else if (ar_ld) begin
         aext_loaded <= 1'b1;
      end
   end

   // Loaded value, visible with the response
   always_ff @(posedge clk) begin
      if (ar_ld) begin
         aext_q <= ar_data;
      end
   end

   // Power-on default until the first AR load
   // ROM position of the switch gives 0x80
   assign aext = aext_loaded ? aext_q : mbu_pkg::default_byte(rom_sel);

endmodule

`default_nettype wire

// File: hdl/mbu.sv
`timescale 1ns/10ps
`default_nettype none

// Memory bank unit
// Eight 8-bit bank registers extending the processor address
module mbu (
   input  logic                        clk,
   input  logic                        rst_n,
   // Request channel
   input  mbu_pkg::mbu_req_t           req,
   input  logic                        req_valid,
   output logic                        req_ready,
   // Response channel
   output mbu_pkg::mbu_rsp_t           rsp,
   output logic                        rsp_valid,
   input  logic                        rsp_ready,
   // Front-panel RAM/ROM switch
   input  logic                        rom_sel,
   // Address extension to AR[23:16]
   output logic [mbu_pkg::BANK_W-1:0]  aext
);

   mbu_pkg::mbu_ctl_t          ctl;
   logic                       wr_en;
   logic                       ar_ld;
   logic [mbu_pkg::IDX_W-1:0]  rd_sel;
   logic [mbu_pkg::BANK_W-1:0] rd_data;
   logic [mbu_pkg::BANK_W-1:0] ar_data;

   //////////////////////////////
   // Decode
   //////////////////////////////

   mbu_addr_decode i_decode (
      .req (req),
      .ctl (ctl)
   );

   //////////////////////////////
   // Control
   //////////////////////////////

   // Enable flag stays internal at this level
   mbu_control i_control (
      .clk       (clk),
      .rst_n     (rst_n),
      .ctl       (ctl),
      .req_valid (req_valid),
      .rsp_ready (rsp_ready),
      .rom_sel   (rom_sel),
      .rd_data   (rd_data),
      .req_ready (req_ready),
      .wr_en     (wr_en),
      .ar_ld     (ar_ld),
      .rd_sel    (rd_sel),
      .ar_data   (ar_data),
      .rsp       (rsp),
      .rsp_valid (rsp_valid),
      .enabled   ()
   );

   //////////////////////////////
   // Register bank
   //////////////////////////////

   // Write data comes straight from the decoded request
   mbu_bank_regs i_bank_regs (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (wr_en),
      .ar_ld   (ar_ld),
      .sel     (rd_sel),
      .wdata   (ctl.wdata),
      .ar_data (ar_data),
      .rom_sel (rom_sel),
      .rd_data (rd_data),
      .aext    (aext)
   );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

// Clock and power-on reset for the testbench
module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   // 10 ns period
   localparam int HALF_NS      = 5;
   localparam int RESET_CYCLES = 4;

   initial begin
      clk = 1'b0;
      forever begin
         #(HALF_NS) clk = ~clk;
      end
   end

   // Reset held low over the first four rising edges
   initial begin
      rst_n <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

// File: testbench/tb_mbu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mbu;

   localparam int NUM_REQ      = 2000;
   localparam int CYC_PER_REQ  = 20;
   localparam int CLK_NS       = 10;
   // Requests sent before I/O writes are allowed
   localparam int DISABLED_REQ = 64;

   // One expected response
   // Data compared only when known
   typedef struct packed {
      logic [7:0]          data;
      logic                known;
      mbu_pkg::mbu_route_e route;
   } exp_rsp_t;

   typedef struct packed {
      mbu_pkg::mbu_func_e func;
      logic [2:0]         idx;
   } access_t;

   logic              clk;
   logic              rst_n;
   mbu_pkg::mbu_req_t req;
   logic              req_valid;
   logic              req_ready;
   mbu_pkg::mbu_rsp_t rsp;
   logic              rsp_valid;
   logic              rsp_ready;
   logic              rom_sel;
   logic [7:0]        aext;

   // Reference model state
   logic [31:0]       lfsr;
   logic [7:0]        model_mb [8];
   logic              model_known [8];
   logic              model_en;
   logic [7:0]        model_aext;
   logic              model_aext_known;
   exp_rsp_t          exp_q [$];
   // Handshake history from the last sample
   logic              req_fire;
   logic              rsp_due;
   logic              rsp_held;
   mbu_pkg::mbu_rsp_t held_rsp;
   int                n_issued;
   int                n_acc;
   int                n_rsp;
   int                err_value;
   int                err_proto;

   tb_clock_gen i_clock_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   mbu i_mbu (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .rsp       (rsp),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rom_sel   (rom_sel),
      .aext      (aext)
   );

   //////////////////////////////
   // Random source
   //////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      lfsr_next = {s[30:0], fb};
   endfunction

   // One step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
      rand_bits = v;
   endfunction

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // Switch in bit 7 and zeros below
   function automatic logic [7:0] power_on_byte(input logic sw);
      power_on_byte = {sw, 7'b000_0000};
   endfunction

   // Priority order is I/O window, MBP read, MBP write, AR load group
   function automatic access_t predict_access(input mbu_pkg::mbu_req_t r);
      access_t a;
      a.func = mbu_pkg::FUNC_NONE;
      a.idx  = 3'd0;
      if ((r.io_rd || r.io_wr) && (r.ab >= 8'h08) && (r.ab <= 8'h0f)) begin
         if (r.io_rd) begin
            a.func = mbu_pkg::FUNC_IO_RD;
         end else begin
            a.func = mbu_pkg::FUNC_IO_WR;
         end
         a.idx = r.ab[2:0];
      end else if (r.raddr == mbu_pkg::RADDR_MBP) begin
         a.func = mbu_pkg::FUNC_CU_RD;
      end else if (r.waddr == mbu_pkg::WADDR_MBP) begin
         a.func = mbu_pkg::FUNC_CU_WR;
      end else if (r.waddr[4:2] == mbu_pkg::WADDR_AR_MBX_HI) begin
         a.func = mbu_pkg::FUNC_AR_LD;
         a.idx  = r.idxen ? r.ir : {1'b0, r.waddr[1:0]};
      end
      predict_access = a;
   endfunction

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   // Random fields then a bias toward one decoded code
   task automatic make_request(output mbu_pkg::mbu_req_t r, input logic io_wr_ok);
      logic [31:0] v;
      logic [31:0] kind;
      v    = rand_bits(32);
      r    = v;
      kind = rand_bits(3);
      case (kind[2:0])
         3'd0, 3'd1: begin
            r.io_wr = 1'b1;
            r.io_rd = 1'b0;
            r.ab    = {mbu_pkg::IO_BASE_HI, v[2:0]};
         end
         3'd2: begin
            // io_wr left random to exercise read priority
            r.io_rd = 1'b1;
            r.ab    = {mbu_pkg::IO_BASE_HI, v[5:3]};
         end
         3'd3: r.raddr = mbu_pkg::RADDR_MBP;
         3'd4: r.waddr = mbu_pkg::WADDR_MBP;
         3'd5: r.waddr = {mbu_pkg::WADDR_AR_MBX_HI, v[9:8]};
         3'd6: begin
            // MBP through I/O address 0x08
            r.io_wr = 1'b1;
            r.io_rd = 1'b0;
            r.ab    = 8'h08;
         end
         default: begin
         end
      endcase
      if (!io_wr_ok) begin
         r.io_wr = 1'b0;
      end
   endtask

   // Runs on the rising edge
   task automatic drive_inputs();
      mbu_pkg::mbu_req_t r;
      logic [31:0]       v;
      // Stall responses a quarter of the time
      v = rand_bits(2);
      rsp_ready <= (v[1:0] != 2'b00);
      if (!req_valid || req_fire) begin
         v = rand_bits(2);
         if ((n_issued < NUM_REQ) && (v[1:0] != 2'b00)) begin
            make_request(r, n_issued >= DISABLED_REQ);
            req       <= r;
            req_valid <= 1'b1;
            n_issued++;
         end else begin
            req_valid <= 1'b0;
         end
      end
   endtask

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Runs on the falling edge where every output is settled
   task automatic check_cycle();
      exp_rsp_t e;
      access_t  a;
      logic     pending;
      // Model view of an outstanding response
      pending = rsp_due || rsp_held;
      // Valid only right after a read or load or while held
      assert (rsp_valid == pending) else begin
         err_proto++;
         $display("Protocol failure at %0t: response valid is %0b, expected %0b",
                  $time, rsp_valid, pending);
      end
      if (rsp_held) begin
         assert (rsp == held_rsp) else begin
            err_value++;
            $display("ERR %0t: response changed while waiting for rsp_ready", $time);
         end
      end
      // Ready with a free slot or while the pending response leaves
      assert (req_ready == (!pending || rsp_ready)) else begin
         err_value++;
         $display("ERR %0t: req_ready is %0b", $time, req_ready);
      end
      if (model_aext_known) begin
         assert (aext == model_aext) else begin
            err_value++;
            $display("ERR %0t: aext %02h, expected %02h", $time, aext, model_aext);
         end
      end
      req_fire = req_valid && req_ready;
      rsp_held = pending && !rsp_ready;
      rsp_due  = 1'b0;
      held_rsp = rsp;
      // Oldest expected response leaves first
      if (rsp_valid && rsp_ready) begin
         if (exp_q.size() == 0) begin
            err_proto++;
            $display("Protocol failure at %0t: response with nothing pending", $time);
         end else begin
            e = exp_q.pop_front();
            n_rsp++;
            assert (rsp.route == e.route) else begin
               err_value++;
               $display("ERR %0t: route %0d, expected %0d", $time, rsp.route, e.route);
            end
            if (e.known) begin
               assert (rsp.data == e.data) else begin
                  err_value++;
                  $display("ERR %0t: data %02h, expected %02h", $time, rsp.data, e.data);
               end
            end
         end
      end
      if (req_fire) begin
         a = predict_access(req);
         n_acc++;
         // Disabled bank reads as the power-on byte
         e.route = mbu_pkg::ROUTE_IBUS;
         e.data  = power_on_byte(rom_sel);
         e.known = 1'b1;
         if (model_en) begin
            e.data  = model_mb[a.idx];
            e.known = model_known[a.idx];
         end
         case (a.func)
            mbu_pkg::FUNC_IO_WR, mbu_pkg::FUNC_CU_WR: begin
               model_mb[a.idx]    = req.data;
               model_known[a.idx] = 1'b1;
               if (a.func == mbu_pkg::FUNC_IO_WR) begin
                  model_en = 1'b1;
               end
            end
            mbu_pkg::FUNC_IO_RD, mbu_pkg::FUNC_CU_RD, mbu_pkg::FUNC_AR_LD: begin
               if (a.func == mbu_pkg::FUNC_IO_RD) begin
                  e.route = mbu_pkg::ROUTE_DB;
               end
               if (a.func == mbu_pkg::FUNC_AR_LD) begin
                  e.route          = mbu_pkg::ROUTE_AR;
                  model_aext       = e.data;
                  model_aext_known = e.known;
               end
               exp_q.push_back(e);
               rsp_due = 1'b1;
            end
            default: begin
            end
         endcase
      end
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      logic [31:0] v;
      lfsr      = 32'hc58f1b9f;
      n_issued  = 0;
      n_acc     = 0;
      n_rsp     = 0;
      err_value = 0;
      err_proto = 0;
      req_fire  = 1'b0;
      rsp_due   = 1'b0;
      rsp_held  = 1'b0;
      model_en  = 1'b0;
      for (int i = 0; i < 8; i++) begin
         model_known[i] = 1'b0;
      end
      // Static switch position for the whole run
      v = rand_bits(1);
      rom_sel          <= v[0];
      model_aext       = power_on_byte(v[0]);
      model_aext_known = 1'b1;
      req              <= '0;
      req_valid        <= 1'b0;
      rsp_ready        <= 1'b0;
      wait (rst_n === 1'b1);
      @(negedge clk);
      assert (!rsp_valid && req_ready) else begin
         err_proto++;
         $display("Reset failure: response valid or request not ready after reset");
      end
      while ((n_acc < NUM_REQ) || req_valid || rsp_valid || (exp_q.size() != 0)) begin
         check_cycle();
         @(posedge clk);
         drive_inputs();
         @(negedge clk);
      end
      $display("Requests %0d, responses %0d, value errors %0d, protocol errors %0d",
               n_acc, n_rsp, err_value, err_proto);
      if ((err_value == 0) && (err_proto == 0)) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // Generous bound on the run length
   initial begin
      #(NUM_REQ * CYC_PER_REQ * CLK_NS);
      $display("Watchdog expired: run did not finish, %0d requests accepted", n_acc);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: mbu.f
hdl/mbu_pkg.sv
hdl/mbu_addr_decode.sv
hdl/mbu_control.sv
hdl/mbu_bank_regs.sv
hdl/mbu.sv
testbench/tb_clock_gen.sv
testbench/tb_mbu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_mbu -f mbu.f \
   && ./obj_dir/Vtb_mbu | tee /dev/stderr | grep -x '\*\*\* PASSED \*\*\*' > /dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
